//--- dcache_golden.txt
# op(1=store) uncached addr wdata wstrb expected_rdata check
# check: 0 none, 1 compare rdata, 2 compare rdata and require a one-cycle hit
0 0 00001010 00000000 0 deadaeff 1
0 0 00001010 00000000 0 deadaeff 2
0 0 00001018 00000000 0 deadaef7 2
1 0 00001014 11223344 5 00000000 0
0 0 00001014 00000000 0 de22ae44 2
1 0 00002024 cafef00d 3 00000000 0
0 0 00002024 00000000 0 deadf00d 2
0 0 00002028 00000000 0 dead9ec7 2
0 0 00005014 00000000 0 deadeefb 1
0 0 00001014 00000000 0 de22ae44 1
0 0 00001010 00000000 0 deadaeff 2
1 1 00008040 89abcdef c 00000000 0
0 1 00008040 00000000 0 89ab3eaf 1
0 1 00008044 00000000 0 dead3eab 1

//--- filelist.f
dcache_pkg.sv
dcache_merge.sv
dcache_line_store.sv
dcache_ctrl.sv
dcache_top.sv
tb_clock_gen.sv
dcache_assertions.sv
tb_dcache.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - dcache_pkg.sv
  - dcache_merge.sv
  - dcache_line_store.sv
  - dcache_ctrl.sv
  - dcache_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - dcache_assertions.sv
      - tb_dcache.sv

//--- tb_dcache.sv
module tb_dcache;
    timeunit 1ns;
    timeprecision 100ps;
    import dcache_pkg::*;

    localparam int cycles_per_request = 40;
    localparam int expected_writebacks = 1;  // only index 1 is ever evicted dirty

    logic  clk;
    logic  reset;
    logic  req_valid;
    logic  req_op;
    addr_t req_addr;
    word_t req_wdata;
    strb_t req_wstrb;
    logic  req_uncached;
    logic  addr_ok;
    logic  data_ok;
    word_t rdata;
    logic  rd_req;
    addr_t rd_addr;
    logic  rd_rdy = 1'b0;
    logic  ret_valid = 1'b0;
    line_t ret_data = '0;
    logic  wr_req;
    addr_t wr_addr;
    line_t wr_data;
    logic  wr_rdy = 1'b0;
    logic  ud_rd_req;
    addr_t ud_rd_addr;
    logic  ud_rd_rdy = 1'b0;
    logic  ud_ret_valid = 1'b0;
    word_t ud_ret_data = '0;
    logic  ud_wr_req;
    addr_t ud_wr_addr;
    word_t ud_wr_data;
    strb_t ud_wr_strb;
    logic  ud_wr_rdy = 1'b0;

    // one golden entry per request
    int    gold_op[$];
    int    gold_uc[$];
    addr_t gold_addr[$];
    word_t gold_wdata[$];
    strb_t gold_wstrb[$];
    word_t gold_rdata[$];
    int    gold_check[$];

    word_t       mem [addr_t];
    logic [31:0] lfsr = 32'h5c97;
    int          rd_gap = 0;
    int          wr_gap = 0;
    int          urd_gap = 0;
    int          uwr_gap = 0;
    int          ret_gap = 0;
    int          uret_gap = 0;
    logic        ret_busy = 1'b0;
    logic        uret_busy = 1'b0;
    line_t       ret_line = '0;
    word_t       uret_word = '0;
    int          writebacks = 0;
    int          errors = 0;
    int          checks = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    logic        started = 1'b0;

    tb_clock_gen tb_clock_gen_i (.clk(clk));

    dcache_top dcache_top_i (.*);

    function automatic logic next_random_bit();
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        return lfsr[0];
    endfunction

    function automatic int random_delay();
        int d;
        d = next_random_bit();
        d = 2 * d + next_random_bit();
        return d;
    endfunction

    // untouched words read back as address ^ deadbeef
    function automatic word_t read_word(addr_t a);
        return mem.exists(a) ? mem[a] : (a ^ 32'hdead_beef);
    endfunction

    function automatic void store_bytes(addr_t a, word_t d, strb_t s);
        addr_t key;
        word_t w;
        key = {a[ADDR_W-1:2], 2'b00};
        w = read_word(key);
        for (int b = 0; b < STRB_W; b++) begin
            if (s[b]) begin
                w[b*8 +: 8] = d[b*8 +: 8];
            end
        end
        mem[key] = w;
    endfunction

    function automatic logic count_down(inout int gap);
        logic ready;
        ready = (gap == 0);
        if (gap > 0) begin
            gap--;
        end
        return ready;
    endfunction

    // memory model samples strobes mid-cycle and answers after the next edge
    always begin
        @(negedge clk);
        if (!reset) begin
            if (wr_req) begin
                for (int w = 0; w < WORDS_PER_LINE; w++) begin
                    mem[wr_addr + 4 * w] = wr_data[w*WORD_W +: WORD_W];
                end
                writebacks++;
                wr_gap = random_delay();
            end
            if (rd_req) begin
                for (int w = 0; w < WORDS_PER_LINE; w++) begin
                    ret_line[w*WORD_W +: WORD_W] = read_word(rd_addr + 4 * w);
                end
                ret_busy = 1'b1;
                ret_gap  = random_delay();
                rd_gap   = random_delay();
            end
            if (ud_wr_req) begin
                store_bytes(ud_wr_addr, ud_wr_data, ud_wr_strb);
                uwr_gap = random_delay();
            end
            if (ud_rd_req) begin
                uret_word = read_word({ud_rd_addr[ADDR_W-1:2], 2'b00});
                uret_busy = 1'b1;
                uret_gap  = random_delay();
                urd_gap   = random_delay();
            end
        end
        @(posedge clk);
        #10;
        rd_rdy    = count_down(rd_gap);
        wr_rdy    = count_down(wr_gap);
        ud_rd_rdy = count_down(urd_gap);
        ud_wr_rdy = count_down(uwr_gap);
        ret_valid = ret_busy && (ret_gap == 0);
        ret_data  = ret_line;
        if (ret_valid) begin
            ret_busy = 1'b0;
        end else if (ret_busy) begin
            ret_gap--;
        end
        ud_ret_valid = uret_busy && (uret_gap == 0);
        ud_ret_data  = uret_word;
        if (ud_ret_valid) begin
            uret_busy = 1'b0;
        end else if (uret_busy) begin
            uret_gap--;
        end
    end

    // nothing may move before the first request
    always @(negedge clk) begin
        if (!reset && !started) begin
            if (rd_req || wr_req || ud_rd_req || ud_wr_req || data_ok) begin
                errors++;
                $display("memory strobe or data_ok seen before the first request");
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("run timed out after %0d cycles", cycle_count);
            $display("Something failed");
            $finish;
        end
    end

    task automatic load_golden();
        int    fd;
        string text;
        int    op;
        int    uc;
        int    chk;
        addr_t a;
        word_t wd;
        strb_t st;
        word_t rd;
        fd = $fopen("dcache_golden.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open dcache_golden.txt");
            return;
        end
        while ($fgets(text, fd) != 0) begin
            if (text[0] == "#") begin
                continue;
            end
            if ($sscanf(text, "%d %d %h %h %h %h %d", op, uc, a, wd, st, rd, chk) == 7) begin
                gold_op.push_back(op);
                gold_uc.push_back(uc);
                gold_addr.push_back(a);
                gold_wdata.push_back(wd);
                gold_wstrb.push_back(st);
                gold_rdata.push_back(rd);
                gold_check.push_back(chk);
            end
        end
        $fclose(fd);
    endtask

    task automatic run_request(input int n);
        int latency;
        @(posedge clk);
        #10;
        started      = 1'b1;
        req_valid    = 1'b1;
        req_op       = gold_op[n][0];
        req_uncached = gold_uc[n][0];
        req_addr     = gold_addr[n];
        req_wdata    = gold_wdata[n];
        req_wstrb    = gold_wstrb[n];
        @(negedge clk);
        if (!addr_ok) begin
            errors++;
            $display("request %0d to %h not accepted, addr_ok is low", n, gold_addr[n]);
        end
        latency = 0;
        do begin
            @(posedge clk);
            #10;
            req_valid = 1'b0;
            @(negedge clk);
            latency++;
            if (gold_uc[n] != 0 && (rd_req || wr_req)) begin
                errors++;
                $display("cached memory request during uncached access to %h", gold_addr[n]);
            end
        end while (!data_ok);
        if (gold_check[n] != 0) begin
            checks++;
            if (rdata !== gold_rdata[n]) begin
                errors++;
                $display("** Error at %0t: addr %h expected %h got %h",
                         $time, gold_addr[n], gold_rdata[n], rdata);
            end
        end
        if (gold_check[n] == 2 && latency != 1) begin  // hit must answer next cycle
            errors++;
            $display("** Error at %0t: addr %h hit latency expected 1 got %0d",
                     $time, gold_addr[n], latency);
        end
    endtask

    initial begin
        reset        = 1'b1;
        req_valid    = 1'b0;
        req_op       = 1'b0;
        req_addr     = '0;
        req_wdata    = '0;
        req_wstrb    = '0;
        req_uncached = 1'b0;
        load_golden();
        cycle_limit = gold_op.size() * cycles_per_request;
        repeat (5) @(posedge clk);
        #10;
        reset = 1'b0;
        @(negedge clk);
        checks++;
        if (addr_ok !== 1'b1) begin
            errors++;
            $display("** Error at %0t: addr_ok after reset expected 1 got %b", $time, addr_ok);
        end
        for (int n = 0; n < gold_op.size(); n++) begin
            run_request(n);
        end
        checks++;
        if (writebacks != expected_writebacks) begin
            errors++;
            $display("** Error at %0t: write-backs expected %0d got %0d",
                     $time, expected_writebacks, writebacks);
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- dcache_assertions.sv
module dcache_assertions (
    input logic              clk,
    input logic              reset,
    input logic              addr_ok,
    input logic              data_ok,
    input logic              rd_req,
    input logic              rd_rdy,
    input dcache_pkg::addr_t rd_addr,
    input logic              wr_req,
    input logic              wr_rdy,
    input logic              ud_rd_req,
    input logic              ud_rd_rdy,
    input logic              ud_wr_req,
    input logic              ud_wr_rdy
);
    timeunit 1ns;
    timeprecision 100ps;
    import dcache_pkg::*;

    // memory strobes only with their own ready
    rd_req_with_ready: assert property (@(posedge clk) disable iff (reset) rd_req |-> rd_rdy)
        else $error("rd_req high without rd_rdy");
    wr_req_with_ready: assert property (@(posedge clk) disable iff (reset) wr_req |-> wr_rdy)
        else $error("wr_req high without wr_rdy");
    ud_rd_req_with_ready: assert property (
        @(posedge clk) disable iff (reset) ud_rd_req |-> ud_rd_rdy)
        else $error("ud_rd_req high without ud_rd_rdy");
    ud_wr_req_with_ready: assert property (
        @(posedge clk) disable iff (reset) ud_wr_req |-> ud_wr_rdy)
        else $error("ud_wr_req high without ud_wr_rdy");

    rd_addr_aligned: assert property (
        @(posedge clk) disable iff (reset) rd_req |-> (rd_addr[INDEX_LSB-1:0] == '0))
        else $error("rd_addr %h is not line aligned", rd_addr);

    ok_flags_exclusive: assert property (@(posedge clk) disable iff (reset) !(data_ok && addr_ok))
        else $error("data_ok and addr_ok high in the same cycle");

endmodule

bind dcache_top dcache_assertions dcache_assertions_i (.*);

//--- tb_clock_gen.sv
module tb_clock_gen (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam time half_period = 50ns;  // 100 ns clock

    initial begin
        clk = 1'b0;
        forever begin
            #half_period clk = ~clk;
        end
    end

endmodule

//--- dcache_top.sv
module dcache_top (
    input  logic              clk,
    input  logic              reset,
    input  logic              req_valid,
    input  logic              req_op,
    input  dcache_pkg::addr_t req_addr,
    input  dcache_pkg::word_t req_wdata,
    input  dcache_pkg::strb_t req_wstrb,
    input  logic              req_uncached,
    output logic              addr_ok,
    output logic              data_ok,
    output dcache_pkg::word_t rdata,
    output logic              rd_req,
    output dcache_pkg::addr_t rd_addr,
    input  logic              rd_rdy,
    input  logic              ret_valid,
    input  dcache_pkg::line_t ret_data,
    output logic              wr_req,
    output dcache_pkg::addr_t wr_addr,
    output dcache_pkg::line_t wr_data,
    input  logic              wr_rdy,
    output logic              ud_rd_req,
    output dcache_pkg::addr_t ud_rd_addr,
    input  logic              ud_rd_rdy,
    input  logic              ud_ret_valid,
    input  dcache_pkg::word_t ud_ret_data,
    output logic              ud_wr_req,
    output dcache_pkg::addr_t ud_wr_addr,
    output dcache_pkg::word_t ud_wr_data,
    output dcache_pkg::strb_t ud_wr_strb,
    input  logic              ud_wr_rdy
);
    import dcache_pkg::*;

    tag_t      hit_tag;
    logic      hit_valid;
    logic      hit_dirty;
    index_t    line_index;
    logic      line_we;
    logic      dirty_set;
    logic      line_from_refill;
    logic      cur_op;
    word_sel_t cur_wsel;
    word_t     cur_wdata;
    strb_t     cur_wstrb;
    line_t     new_line;
    word_t     load_word;

    dcache_ctrl dcache_ctrl_i (
        .clk              (clk),
        .reset            (reset),
        .req_valid        (req_valid),
        .req_op           (req_op),
        .req_addr         (req_addr),
        .req_wdata        (req_wdata),
        .req_wstrb        (req_wstrb),
        .req_uncached     (req_uncached),
        .hit_tag          (hit_tag),
        .hit_valid        (hit_valid),
        .hit_dirty        (hit_dirty),
        .rd_rdy           (rd_rdy),
        .ret_valid        (ret_valid),
        .wr_rdy           (wr_rdy),
        .ud_rd_rdy        (ud_rd_rdy),
        .ud_ret_valid     (ud_ret_valid),
        .ud_wr_rdy        (ud_wr_rdy),
        .addr_ok          (addr_ok),
        .data_ok          (data_ok),
        .rd_req           (rd_req),
        .rd_addr          (rd_addr),
        .wr_req           (wr_req),
        .wr_addr          (wr_addr),
        .ud_rd_req        (ud_rd_req),
        .ud_wr_req        (ud_wr_req),
        .ud_addr          (ud_rd_addr),
        .ud_wr_data       (ud_wr_data),
        .ud_wr_strb       (ud_wr_strb),
        .line_index       (line_index),
        .line_we          (line_we),
        .dirty_set        (dirty_set),
        .line_from_refill (line_from_refill),
        .cur_op           (cur_op),
        .cur_wsel         (cur_wsel),
        .cur_wdata        (cur_wdata),
        .cur_wstrb        (cur_wstrb)
    );

    dcache_line_store dcache_line_store_i (
        .clk        (clk),
        .reset      (reset),
        .index      (line_index),
        .we         (line_we),
        .dirty_set  (dirty_set),
        .new_tag    (rd_addr[ADDR_W-1:TAG_LSB]),  // tag of the latched request
        .wdata_line (new_line),
        .tag        (hit_tag),
        .valid      (hit_valid),
        .dirty      (hit_dirty),
        .rdata_line (wr_data)                       // also the write-back line
    );

    dcache_merge dcache_merge_i (
        .old_line    (wr_data),
        .ret_line    (ret_data),
        .from_refill (line_from_refill),
        .is_store    (cur_op),
        .wsel        (cur_wsel),
        .wdata       (cur_wdata),
        .wstrb       (cur_wstrb),
        .new_line    (new_line),
        .load_word   (load_word)
    );

    assign ud_wr_addr = ud_rd_addr;

    // uncached return only arrives while an uncached load waits
    assign rdata = ud_ret_valid ? ud_ret_data : load_word;

endmodule

//--- dcache_ctrl.sv
module dcache_ctrl (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req_valid,
    input  logic                  req_op,
    input  dcache_pkg::addr_t     req_addr,
    input  dcache_pkg::word_t     req_wdata,
    input  dcache_pkg::strb_t     req_wstrb,
    input  logic                  req_uncached,
    input  dcache_pkg::tag_t      hit_tag,
    input  logic                  hit_valid,
    input  logic                  hit_dirty,
    input  logic                  rd_rdy,
    input  logic                  ret_valid,
    input  logic                  wr_rdy,
    input  logic                  ud_rd_rdy,
    input  logic                  ud_ret_valid,
    input  logic                  ud_wr_rdy,
    output logic                  addr_ok,
    output logic                  data_ok,
    output logic                  rd_req,
    output dcache_pkg::addr_t     rd_addr,
    output logic                  wr_req,
    output dcache_pkg::addr_t     wr_addr,
    output logic                  ud_rd_req,
    output logic                  ud_wr_req,
    output dcache_pkg::addr_t     ud_addr,
    output dcache_pkg::word_t     ud_wr_data,
    output dcache_pkg::strb_t     ud_wr_strb,
    output dcache_pkg::index_t    line_index,
    output logic                  line_we,
    output logic                  dirty_set,
    output logic                  line_from_refill,
    output logic                  cur_op,
    output dcache_pkg::word_sel_t cur_wsel,
    output dcache_pkg::word_t     cur_wdata,
    output dcache_pkg::strb_t     cur_wstrb
);
    import dcache_pkg::*;

    cache_state_t state;
    cache_state_t next_state;
    addr_t        cur_addr;
    tag_t         cur_tag;
    index_t       cur_index;
    logic         hit;

    // request capture only while idle
    always_ff @(posedge clk) begin
        if (state == IDLE && req_valid) begin
            cur_op    <= req_op;
            cur_addr  <= req_addr;
            cur_wdata <= req_wdata;
            cur_wstrb <= req_wstrb;
        end
    end

    assign cur_tag   = cur_addr[ADDR_W-1:TAG_LSB];
    assign cur_index = cur_addr[TAG_LSB-1:INDEX_LSB];
    assign cur_wsel  = cur_addr[INDEX_LSB-1:WORD_LSB];

    assign hit = hit_valid && (hit_tag == cur_tag);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (req_valid) begin
                    if (req_uncached) begin
                        next_state = req_op ? UC_WRITE : UC_READ;
                    end else begin
                        next_state = LOOKUP;
                    end
                end
            end
            LOOKUP: begin
                if (hit) begin
                    next_state = IDLE;
                end else if (hit_valid && hit_dirty) begin
                    next_state = WRITEBACK;
                end else begin
                    next_state = FETCH;
                end
            end
            WRITEBACK: if (wr_rdy) next_state = FETCH;
            FETCH:     if (rd_rdy) next_state = REFILL;
            REFILL:    if (ret_valid) next_state = IDLE;
            UC_READ:   if (ud_rd_rdy) next_state = UC_WAIT;
            UC_WAIT:   if (ud_ret_valid) next_state = IDLE;
            UC_WRITE:  if (ud_wr_rdy) next_state = IDLE;
            default:   next_state = IDLE;
        endcase
    end

    assign addr_ok = (state == IDLE);
    assign data_ok = (state == LOOKUP && hit) ||
                     (state == REFILL && ret_valid) ||
                     (state == UC_WAIT && ud_ret_valid) ||
                     (state == UC_WRITE && ud_wr_rdy);

    // strobes only go up with their ready
    assign rd_req    = (state == FETCH) && rd_rdy;
    assign wr_req    = (state == WRITEBACK) && wr_rdy;
    assign ud_rd_req = (state == UC_READ) && ud_rd_rdy;
    assign ud_wr_req = (state == UC_WRITE) && ud_wr_rdy;

    assign rd_addr = {cur_tag, cur_index, {INDEX_LSB{1'b0}}};
    assign wr_addr = {hit_tag, cur_index, {INDEX_LSB{1'b0}}};  // victim address

    assign ud_addr    = cur_addr;
    assign ud_wr_data = cur_wdata;
    assign ud_wr_strb = cur_wstrb;

    // incoming index feeds the sync read in idle
    assign line_index = (state == IDLE) ? req_addr[TAG_LSB-1:INDEX_LSB] : cur_index;

    assign line_we = (state == LOOKUP && hit && cur_op) ||
                     (state == REFILL && ret_valid);
    assign dirty_set        = cur_op;  // loads refill clean
    assign line_from_refill = (state == REFILL);

endmodule

//--- dcache_line_store.sv
module dcache_line_store (
    input  logic               clk,
    input  logic               reset,
    input  dcache_pkg::index_t index,
    input  logic               we,
    input  logic               dirty_set,
    input  dcache_pkg::tag_t   new_tag,
    input  dcache_pkg::line_t  wdata_line,
    output dcache_pkg::tag_t   tag,
    output logic               valid,
    output logic               dirty,
    output dcache_pkg::line_t  rdata_line
);
    import dcache_pkg::*;

    tag_t                tag_mem [NUM_SETS];
    logic [NUM_SETS-1:0] valid_bits;
    logic [NUM_SETS-1:0] dirty_bits;

    // status bits
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
            dirty_bits <= '0;
            valid      <= 1'b0;
            dirty      <= 1'b0;
        end else begin
            valid <= valid_bits[index];
            dirty <= dirty_bits[index];
            if (we) begin
                valid_bits[index] <= 1'b1;
                dirty_bits[index] <= dirty_set;
            end
        end
    end

    always_ff @(posedge clk) begin
        tag <= tag_mem[index];
        if (we) begin
            tag_mem[index] <= new_tag;
        end
    end

    // one bank per word of the line
    for (genvar w = 0; w < WORDS_PER_LINE; w++) begin : g_bank
        word_t bank_mem [NUM_SETS];

        always_ff @(posedge clk) begin
            rdata_line[w*WORD_W +: WORD_W] <= bank_mem[index];
            if (we) begin
                bank_mem[index] <= wdata_line[w*WORD_W +: WORD_W];
            end
        end
    end

endmodule

//--- dcache_merge.sv
module dcache_merge (
    input  dcache_pkg::line_t     old_line,
    input  dcache_pkg::line_t     ret_line,
    input  logic                  from_refill,
    input  logic                  is_store,
    input  dcache_pkg::word_sel_t wsel,
    input  dcache_pkg::word_t     wdata,
    input  dcache_pkg::strb_t     wstrb,
    output dcache_pkg::line_t     new_line,
    output dcache_pkg::word_t     load_word
);
    import dcache_pkg::*;

    line_t base_line;

    assign base_line = from_refill ? ret_line : old_line;

    // byte lanes of the selected word take store data
    always_comb begin
        new_line = base_line;
        if (is_store) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (wstrb[b]) begin
                    new_line[wsel*WORD_W + b*8 +: 8] = wdata[b*8 +: 8];
                end
            end
        end
    end

    assign load_word = base_line[wsel*WORD_W +: WORD_W];  // pre-merge word

endmodule

//--- dcache_pkg.sv
package dcache_pkg;

    // bus widths
    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_W = WORD_W * WORDS_PER_LINE;
    localparam int STRB_W = WORD_W / 8;

    // address field positions
    localparam int TAG_LSB = 12;
    localparam int INDEX_LSB = 4;
    localparam int WORD_LSB = 2;

    localparam int TAG_W = ADDR_W - TAG_LSB;
    localparam int INDEX_W = TAG_LSB - INDEX_LSB;
    localparam int WSEL_W = INDEX_LSB - WORD_LSB;

    localparam int NUM_SETS = 256;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [LINE_W-1:0] line_t;
    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [WSEL_W-1:0] word_sel_t;
    typedef logic [STRB_W-1:0] strb_t;

    // controller states
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,  // dirty victim goes out first
        FETCH,
        REFILL,
        UC_READ,
        UC_WAIT,
        UC_WRITE
    } cache_state_t;

endpackage
